// File: Makefile
TOP = fabricTb
LOG = sim.log

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

lint:
	verilator --lint-only -Wall --timing -f flist.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)

// File: flist.f
+incdir+rtl
rtl/fabricBusPkg.sv
rtl/vcomPkg.sv
rtl/fabricRegisters.sv
rtl/vcomGenerator.sv
rtl/fabricTop.sv
test/fabricChecker.sv
test/fabricMonitor.sv
test/fabricTb.sv

// File: rtl/fabricBusPkg.sv
`include "fabric_macros.svh"

package fabricBusPkg;

    // ------------------------------------------------------------------------
    // Bus word views
    // ------------------------------------------------------------------------

    // One bus word split into its byte lanes, lane 0 in bits 7:0
    typedef logic [(`FABRIC_DATA_WIDTH/8)-1:0][7:0] byteLanesT;

    // Clock control register layout
    typedef struct packed
    {
        // Unused upper bits, read as zero
        logic [`FABRIC_DATA_WIDTH-2:0] reserved;
        // Requests the VCOM square wave
        logic vcomEnable;
    } clkCtrlT;

    // ------------------------------------------------------------------------
    // Write word, decoded two ways
    // ------------------------------------------------------------------------

    // Byte lanes for strobe masking of the GPIO registers
    // Control view for the clock control register
    typedef union packed
    {
        byteLanesT lanes;
        clkCtrlT ctrl;
    } wrWordU;

endpackage

// File: rtl/fabricRegisters.sv
`timescale 1ns/1ps

`include "fabric_macros.svh"

module fabricRegisters
(
    // Wishbone slave
    input  logic                            wbsClk_i,
    input  logic                            wbsRst_i,
    input  logic [`FABRIC_ADDR_WIDTH-1:0]   wbsAdr_i,
    input  logic                            wbsCyc_i,
    input  logic                            wbsStb_i,
    input  logic                            wbsWe_i,
    input  logic [`FABRIC_DATA_WIDTH/8-1:0] wbsByteStb_i,
    input  logic [`FABRIC_DATA_WIDTH-1:0]   wbsDat_i,
    output logic [`FABRIC_DATA_WIDTH-1:0]   wbsDat_o,
    output logic                            wbsAck_o,

    // GPIO pins
    input  logic [`GPIO_WIDTH-1:0]          gpioIn_i,
    output logic [`GPIO_WIDTH-1:0]          gpioOut_o,
    output logic [`GPIO_WIDTH-1:0]          gpioOe_o,

    // Towards the VCOM generator, bus clock domain
    output logic                            vcomEnable_o
);

    // ------------------------------------------------------------------------
    // Internal signals
    // ------------------------------------------------------------------------

    // New request, not yet acknowledged
    logic reqNew;
    logic wrReq;

    // One write enable per writable register
    logic ctrlWrEn;
    logic gpioOutWrEn;
    logic gpioOeWrEn;

    // Write data and current register contents as bus words
    fabricBusPkg::wrWordU wrWord;
    fabricBusPkg::wrWordU curOutWord;
    fabricBusPkg::wrWordU curOeWord;
    fabricBusPkg::wrWordU nextOutWord;
    fabricBusPkg::wrWordU nextOeWord;

    // Control register as read back
    fabricBusPkg::clkCtrlT ctrlView;

    // ------------------------------------------------------------------------
    // Byte strobe merge for the GPIO registers
    // ------------------------------------------------------------------------

    // Bits 21:16 both live in lane 2 of the data word
    // Lane 2 strobe covers bits 19:16, lane 3 strobe covers bits 21:20
    function automatic fabricBusPkg::wrWordU mergeGpio
    (
        input fabricBusPkg::wrWordU cur,
        input fabricBusPkg::wrWordU wr,
        input logic [`FABRIC_DATA_WIDTH/8-1:0] stb
    );
        fabricBusPkg::wrWordU res;
        res = cur;
        if (stb[0])
            res.lanes[0] = wr.lanes[0];
        if (stb[1])
            res.lanes[1] = wr.lanes[1];
        if (stb[2])
            res.lanes[2][3:0] = wr.lanes[2][3:0];
        if (stb[3])
            res.lanes[2][5:4] = wr.lanes[2][5:4];
        return res;
    endfunction

    // ------------------------------------------------------------------------
    // Request decode
    // ------------------------------------------------------------------------

    // Held request is ignored during its acknowledge cycle
    assign reqNew = wbsCyc_i & wbsStb_i & ~wbsAck_o;
    assign wrReq = reqNew & wbsWe_i;

    assign ctrlWrEn = wrReq & (wbsAdr_i == `ADR_CLK_CTRL);
    assign gpioOutWrEn = wrReq & (wbsAdr_i == `ADR_GPIO_OUT);
    assign gpioOeWrEn = wrReq & (wbsAdr_i == `ADR_GPIO_OE);

    assign wrWord = wbsDat_i;

    // Zero extended register views for the merge
    assign curOutWord = {{(`FABRIC_DATA_WIDTH-`GPIO_WIDTH){1'b0}}, gpioOut_o};
    assign curOeWord = {{(`FABRIC_DATA_WIDTH-`GPIO_WIDTH){1'b0}}, gpioOe_o};

    assign nextOutWord = mergeGpio(curOutWord, wrWord, wbsByteStb_i);
    assign nextOeWord = mergeGpio(curOeWord, wrWord, wbsByteStb_i);

    // ------------------------------------------------------------------------
    // Registers and acknowledge
    // ------------------------------------------------------------------------
    always_ff @(posedge wbsClk_i or posedge wbsRst_i)
    begin
        if (wbsRst_i)
        begin
            wbsAck_o <= 1'b0;
            vcomEnable_o <= 1'b0;
            gpioOut_o <= `GPIO_OUT_RST;
            gpioOe_o <= `GPIO_OE_RST;
        end
        else
        begin
            // Single cycle acknowledge, write lands on the same edge
            wbsAck_o <= reqNew;

            // Enable bit sits in lane 0
            if (ctrlWrEn && wbsByteStb_i[0])
                vcomEnable_o <= wrWord.ctrl.vcomEnable;

            if (gpioOutWrEn)
                gpioOut_o <= nextOutWord[`GPIO_WIDTH-1:0];

            if (gpioOeWrEn)
                gpioOe_o <= nextOeWord[`GPIO_WIDTH-1:0];
        end
    end

    // ------------------------------------------------------------------------
    // Read multiplexer
    // ------------------------------------------------------------------------
    assign ctrlView.reserved = '0;
    assign ctrlView.vcomEnable = vcomEnable_o;

    // Address only, no dependence on the request terms
    always_comb
    begin
        case (wbsAdr_i)
            `ADR_DEVICE_ID:
                wbsDat_o = {{(`FABRIC_DATA_WIDTH-24){1'b0}}, `DEVICE_ID_VALUE};
            `ADR_CLK_CTRL:
                wbsDat_o = ctrlView;
            `ADR_GPIO_IN:
                wbsDat_o = {{(`FABRIC_DATA_WIDTH-`GPIO_WIDTH){1'b0}}, gpioIn_i};
            `ADR_GPIO_OUT:
                wbsDat_o = curOutWord;
            `ADR_GPIO_OE:
                wbsDat_o = curOeWord;
            // Unmapped space
            default:
                wbsDat_o = `DEF_REG_VALUE;
        endcase
    end

endmodule

// File: rtl/fabricTop.sv
`timescale 1ns/1ps

`include "fabric_macros.svh"

module fabricTop
(
    // Wishbone slave, bus clock domain
    input  logic                            wbsClk_i,
    input  logic                            wbsRst_i,
    input  logic [`FABRIC_ADDR_WIDTH-1:0]   wbsAdr_i,
    input  logic                            wbsCyc_i,
    input  logic                            wbsStb_i,
    input  logic                            wbsWe_i,
    input  logic [`FABRIC_DATA_WIDTH/8-1:0] wbsByteStb_i,
    input  logic [`FABRIC_DATA_WIDTH-1:0]   wbsDat_i,
    output logic [`FABRIC_DATA_WIDTH-1:0]   wbsDat_o,
    output logic                            wbsAck_o,

    // 32 kHz domain
    input  logic                            CLK_32K_i,
    input  logic                            RST_fb_i,
    input  logic                            lcdVcomEna_i,

    // GPIO pins
    input  logic [`GPIO_WIDTH-1:0]          gpioIn_i,
    output logic [`GPIO_WIDTH-1:0]          gpioOut_o,
    output logic [`GPIO_WIDTH-1:0]          gpioOe_o,

    // LCD common electrode
    output logic                            vcom_o
);

    // Crosses from the bus clock into the 32 kHz domain
    logic vcomEnable;

    // ------------------------------------------------------------------------
    // Register block
    // ------------------------------------------------------------------------
    fabricRegisters regs_i
    (
        .wbsClk_i     (wbsClk_i),
        .wbsRst_i     (wbsRst_i),
        .wbsAdr_i     (wbsAdr_i),
        .wbsCyc_i     (wbsCyc_i),
        .wbsStb_i     (wbsStb_i),
        .wbsWe_i      (wbsWe_i),
        .wbsByteStb_i (wbsByteStb_i),
        .wbsDat_i     (wbsDat_i),
        .wbsDat_o     (wbsDat_o),
        .wbsAck_o     (wbsAck_o),
        .gpioIn_i     (gpioIn_i),
        .gpioOut_o    (gpioOut_o),
        .gpioOe_o     (gpioOe_o),
        .vcomEnable_o (vcomEnable)
    );

    // ------------------------------------------------------------------------
    // VCOM generator
    // ------------------------------------------------------------------------
    vcomGenerator vcom_i
    (
        .CLK_32K_i    (CLK_32K_i),
        .RST_fb_i     (RST_fb_i),
        .vcomEnable_i (vcomEnable),
        .lcdVcomEna_i (lcdVcomEna_i),
        .vcom_o       (vcom_o)
    );

endmodule

// File: rtl/fabric_macros.svh
`ifndef FABRIC_MACROS_SVH
`define FABRIC_MACROS_SVH

// ----------------------------------------------------------------------------
// Bus geometry
// ----------------------------------------------------------------------------
`define FABRIC_ADDR_WIDTH 7
`define FABRIC_DATA_WIDTH 32
`define GPIO_WIDTH 22

// ----------------------------------------------------------------------------
// Register map, word addresses
// ----------------------------------------------------------------------------
`define ADR_DEVICE_ID 7'h0
`define ADR_CLK_CTRL 7'h1
`define ADR_GPIO_IN 7'h2
`define ADR_GPIO_OUT 7'h3
`define ADR_GPIO_OE 7'h4

// Fixed read values
`define DEVICE_ID_VALUE 24'hABC001
`define DEF_REG_VALUE 32'hFABDEFAC

// VCOM half period in 32 kHz cycles
`define VCOM_HALF_PERIOD 274

// Reset values of the writable GPIO registers
`define GPIO_OUT_RST 22'h0
`define GPIO_OE_RST 22'h0

`endif

// File: rtl/vcomGenerator.sv
`timescale 1ns/1ps

`include "fabric_macros.svh"

module vcomGenerator
(
    input  logic CLK_32K_i,
    input  logic RST_fb_i,

    // Enable from the register block, bus clock domain
    input  logic vcomEnable_i,
    // Enable request from the panel, asynchronous
    input  logic lcdVcomEna_i,

    // LCD common electrode drive
    output logic vcom_o
);

    // ------------------------------------------------------------------------
    // Internal signals
    // ------------------------------------------------------------------------
    logic enaAny;
    logic enaMeta;
    logic enaSync;

    // Free running half period counter and internal wave
    vcomPkg::vcomCountT halfCount;
    vcomPkg::vcomLevelE waveLevel;

    // Enable as seen by the output, changes only in the low phase
    logic gatedEna;

    // ------------------------------------------------------------------------
    // Enable synchronizer
    // ------------------------------------------------------------------------

    // Either source may request VCOM
    assign enaAny = vcomEnable_i | lcdVcomEna_i;

    always_ff @(posedge CLK_32K_i or posedge RST_fb_i)
    begin
        if (RST_fb_i)
        begin
            enaMeta <= 1'b0;
            enaSync <= 1'b0;
        end
        else
        begin
            enaMeta <= enaAny;
            enaSync <= enaMeta;
        end
    end

    // ------------------------------------------------------------------------
    // Half period counter
    // ------------------------------------------------------------------------

    // Runs from reset, enabled or not
    always_ff @(posedge CLK_32K_i or posedge RST_fb_i)
    begin
        if (RST_fb_i)
        begin
            halfCount <= '0;
            waveLevel <= vcomPkg::VCOM_LOW;
        end
        else if (halfCount == vcomPkg::vcomCountT'(`VCOM_HALF_PERIOD - 1))
        begin
            halfCount <= '0;
            waveLevel <= (waveLevel == vcomPkg::VCOM_LOW) ? vcomPkg::VCOM_HIGH
                                                          : vcomPkg::VCOM_LOW;
        end
        else
        begin
            halfCount <= halfCount + 1'b1;
        end
    end

    // ------------------------------------------------------------------------
    // Low phase gating
    // ------------------------------------------------------------------------

    // Enable frozen while high, so no pulse is ever cut short
    always_ff @(posedge CLK_32K_i or posedge RST_fb_i)
    begin
        if (RST_fb_i)
            gatedEna <= 1'b0;
        else if (waveLevel == vcomPkg::VCOM_LOW)
            gatedEna <= enaSync;
    end

    assign vcom_o = gatedEna & (waveLevel == vcomPkg::VCOM_HIGH);

endmodule

// File: rtl/vcomPkg.sv
package vcomPkg;

    // ------------------------------------------------------------------------
    // VCOM timing domain types
    // ------------------------------------------------------------------------

    // Half period counter, wide enough for 0 to 273
    typedef logic [8:0] vcomCountT;

    // Level of the free running internal wave
    typedef enum logic
    {
        VCOM_LOW = 1'b0,
        VCOM_HIGH = 1'b1
    } vcomLevelE;

endpackage

// File: test/fabricChecker.sv
`timescale 1ns/1ps

module fabricChecker
(
    input logic wbsClk_i,
    input logic wbsRst_i,
    input logic wbsCyc_i,
    input logic wbsStb_i,
    input logic wbsAck_i,
    input logic CLK_32K_i,
    input logic RST_fb_i,
    input logic vcom_i
);

    // ---------------------------------------------------------------------------
    // Bus protocol
    // ---------------------------------------------------------------------------

    // Acknowledge lasts exactly one bus cycle
    ackSingle: assert property (@(posedge wbsClk_i) disable iff (wbsRst_i)
        wbsAck_i |=> !wbsAck_i)
        else $error("wbsAck_o stayed high for two consecutive cycles");

    // Every acknowledge answers a request seen one edge earlier
    ackAfterReq: assert property (@(posedge wbsClk_i) disable iff (wbsRst_i)
        $rose(wbsAck_i) |-> $past(wbsCyc_i & wbsStb_i))
        else $error("wbsAck_o rose without a preceding request");

    // ---------------------------------------------------------------------------
    // VCOM
    // ---------------------------------------------------------------------------

    // Output still low one cycle after reset
    vcomLowAfterReset: assert property (@(posedge CLK_32K_i)
        $past(RST_fb_i) |-> !vcom_i)
        else $error("vcom_o was high in the cycle after reset");

endmodule

// File: test/fabricMonitor.sv
`timescale 1ns/1ps

`include "fabric_macros.svh"

module fabricMonitor
(
    // Bus side, as seen at the DUT ports
    input logic                            wbsClk_i,
    input logic                            wbsRst_i,
    input logic [`FABRIC_ADDR_WIDTH-1:0]   wbsAdr_i,
    input logic                            wbsWe_i,
    input logic [`FABRIC_DATA_WIDTH/8-1:0] wbsByteStb_i,
    input logic [`FABRIC_DATA_WIDTH-1:0]   wbsDat_i,
    input logic [`FABRIC_DATA_WIDTH-1:0]   rdDat_i,
    input logic                            wbsAck_i,

    // 32 kHz side
    input logic                            CLK_32K_i,
    input logic                            RST_fb_i,
    input logic                            vcom_i,

    // GPIO pins
    input logic [`GPIO_WIDTH-1:0]          gpioIn_i,
    input logic [`GPIO_WIDTH-1:0]          gpioOut_i,
    input logic [`GPIO_WIDTH-1:0]          gpioOe_i
);

    // Reference copies of the writable registers
    logic [`GPIO_WIDTH-1:0] modelOut = '0;
    logic [`GPIO_WIDTH-1:0] modelOe = '0;
    logic modelEna = 1'b0;

    // Bookkeeping per test and overall
    string curTest = "startup";
    int testErrors = 0;
    int errorCount = 0;
    int testCount = 0;
    int failedTests = 0;
    int ackCount = 0;

    // Pulse width measurement
    int highCycles = 0;
    vcomPkg::vcomLevelE lastLevel = vcomPkg::VCOM_LOW;

    // ---------------------------------------------------------------------------
    // Helpers
    // ---------------------------------------------------------------------------
    function automatic void compare(input string what, input logic [31:0] exp,
                                    input logic [31:0] act);
        if (exp !== act)
        begin
            $display("FAIL %s: %s expected %h actual %h", curTest, what, exp, act);
            testErrors++;
            errorCount++;
        end
    endfunction

    // GPIO bits covered by each byte strobe
    function automatic logic [`GPIO_WIDTH-1:0] laneMask(input logic [3:0] stb);
        logic [`GPIO_WIDTH-1:0] mask;
        mask = '0;
        if (stb[0])
            mask[7:0] = '1;
        if (stb[1])
            mask[15:8] = '1;
        if (stb[2])
            mask[19:16] = '1;
        // Top two GPIO bits ride on lane 3
        if (stb[3])
            mask[21:20] = '1;
        return mask;
    endfunction

    // Readable value of every address per the register map
    function automatic logic [31:0] expectedRead(input logic [`FABRIC_ADDR_WIDTH-1:0] adr);
        fabricBusPkg::clkCtrlT ctrl;
        ctrl = '0;
        ctrl.vcomEnable = modelEna;
        case (adr)
            `ADR_DEVICE_ID:
                return 32'(`DEVICE_ID_VALUE);
            `ADR_CLK_CTRL:
                return ctrl;
            `ADR_GPIO_IN:
                return 32'(gpioIn_i);
            `ADR_GPIO_OUT:
                return 32'(modelOut);
            `ADR_GPIO_OE:
                return 32'(modelOe);
            default:
                return `DEF_REG_VALUE;
        endcase
    endfunction

    // Writes to other addresses leave the model alone
    function automatic void applyWrite();
        logic [`GPIO_WIDTH-1:0] mask;
        mask = laneMask(wbsByteStb_i);
        case (wbsAdr_i)
            `ADR_CLK_CTRL:
                if (wbsByteStb_i[0])
                    modelEna = wbsDat_i[0];
            `ADR_GPIO_OUT:
                modelOut = (modelOut & ~mask) | (wbsDat_i[`GPIO_WIDTH-1:0] & mask);
            `ADR_GPIO_OE:
                modelOe = (modelOe & ~mask) | (wbsDat_i[`GPIO_WIDTH-1:0] & mask);
            default:
                ;
        endcase
    endfunction

    // ---------------------------------------------------------------------------
    // Bus transfers
    // ---------------------------------------------------------------------------

    // Request still held during the acknowledge cycle
    always @(posedge wbsClk_i)
    begin
        if (wbsRst_i)
        begin
            modelOut = `GPIO_OUT_RST;
            modelOe = `GPIO_OE_RST;
            modelEna = 1'b0;
        end
        else if (wbsAck_i)
        begin
            ackCount++;
            if (wbsWe_i)
            begin
                applyWrite();
                compare("gpioOut_o pins", 32'(modelOut), 32'(gpioOut_i));
                compare("gpioOe_o pins", 32'(modelOe), 32'(gpioOe_i));
            end
            else
                compare($sformatf("read at %0h", wbsAdr_i), expectedRead(wbsAdr_i), rdDat_i);
        end
    end

    // ---------------------------------------------------------------------------
    // VCOM pulse widths
    // ---------------------------------------------------------------------------
    always @(posedge CLK_32K_i)
    begin
        if (RST_fb_i)
        begin
            highCycles = 0;
            lastLevel = vcomPkg::VCOM_LOW;
        end
        else
        begin
            if (vcom_i)
                highCycles++;
            else if (lastLevel == vcomPkg::VCOM_HIGH)
            begin
                // Falling edge, pulse complete
                compare("vcom high pulse width", `VCOM_HALF_PERIOD, highCycles);
                highCycles = 0;
            end
            lastLevel = vcom_i ? vcomPkg::VCOM_HIGH : vcomPkg::VCOM_LOW;
        end
    end

    // Output must stay low for the whole window
    task automatic checkQuiet(input int cycles);
        int highSeen;
        highSeen = 0;
        repeat (cycles)
        begin
            @(posedge CLK_32K_i);
            if (vcom_i)
                highSeen++;
        end
        compare("vcom high cycles while disabled", 32'd0, highSeen);
    endtask

    // ---------------------------------------------------------------------------
    // Test bookkeeping
    // ---------------------------------------------------------------------------
    task automatic startTest(input string name);
        curTest = name;
        testErrors = 0;
        ackCount = 0;
    endtask

    task automatic checkAckCount(input int expected);
        compare("acknowledge count", expected, ackCount);
    endtask

    task automatic finishTest();
        testCount++;
        if (testErrors != 0)
            failedTests++;
        $display("test %-22s %s, %0d mismatches", curTest,
                 (testErrors == 0) ? "passed" : "failed", testErrors);
    endtask

endmodule

// File: test/fabricTb.sv
`timescale 1ns/1ps

`include "fabric_macros.svh"

module fabricTb;

    // Clocks and resets
    logic wbsClk = 1'b0;
    logic clk32k = 1'b0;
    logic wbsRst;
    logic rstFb;

    // Bus master side
    logic [`FABRIC_ADDR_WIDTH-1:0] wbsAdr;
    logic wbsCyc;
    logic wbsStb;
    logic wbsWe;
    logic [`FABRIC_DATA_WIDTH/8-1:0] wbsByteStb;
    logic [`FABRIC_DATA_WIDTH-1:0] wbsDatWr;
    logic [`FABRIC_DATA_WIDTH-1:0] wbsDatRd;
    logic wbsAck;

    // Pins
    logic lcdVcomEna;
    logic [`GPIO_WIDTH-1:0] gpioIn;
    logic [`GPIO_WIDTH-1:0] gpioOut;
    logic [`GPIO_WIDTH-1:0] gpioOe;
    logic vcom;

    // Set by any wait that ran out
    logic timedOut = 1'b0;

    // 6 ns bus clock, 10 ns stand-in for the 32 kHz clock
    always #3 wbsClk = ~wbsClk;
    always #5 clk32k = ~clk32k;

    // ---------------------------------------------------------------------------
    // DUT, monitor, checker
    // ---------------------------------------------------------------------------
    fabricTop dut_i
    (
        .wbsClk_i     (wbsClk),
        .wbsRst_i     (wbsRst),
        .wbsAdr_i     (wbsAdr),
        .wbsCyc_i     (wbsCyc),
        .wbsStb_i     (wbsStb),
        .wbsWe_i      (wbsWe),
        .wbsByteStb_i (wbsByteStb),
        .wbsDat_i     (wbsDatWr),
        .wbsDat_o     (wbsDatRd),
        .wbsAck_o     (wbsAck),
        .CLK_32K_i    (clk32k),
        .RST_fb_i     (rstFb),
        .lcdVcomEna_i (lcdVcomEna),
        .gpioIn_i     (gpioIn),
        .gpioOut_o    (gpioOut),
        .gpioOe_o     (gpioOe),
        .vcom_o       (vcom)
    );

    fabricMonitor mon_i
    (
        .wbsClk_i     (wbsClk),
        .wbsRst_i     (wbsRst),
        .wbsAdr_i     (wbsAdr),
        .wbsWe_i      (wbsWe),
        .wbsByteStb_i (wbsByteStb),
        .wbsDat_i     (wbsDatWr),
        .rdDat_i      (wbsDatRd),
        .wbsAck_i     (wbsAck),
        .CLK_32K_i    (clk32k),
        .RST_fb_i     (rstFb),
        .vcom_i       (vcom),
        .gpioIn_i     (gpioIn),
        .gpioOut_i    (gpioOut),
        .gpioOe_i     (gpioOe)
    );

    bind fabricTop fabricChecker chk_i
    (
        .wbsClk_i  (wbsClk_i),
        .wbsRst_i  (wbsRst_i),
        .wbsCyc_i  (wbsCyc_i),
        .wbsStb_i  (wbsStb_i),
        .wbsAck_i  (wbsAck_o),
        .CLK_32K_i (CLK_32K_i),
        .RST_fb_i  (RST_fb_i),
        .vcom_i    (vcom_o)
    );

    // ---------------------------------------------------------------------------
    // Bus master and waits
    // ---------------------------------------------------------------------------

    // One transfer, then an idle cycle
    task automatic busAccess
    (
        input logic [`FABRIC_ADDR_WIDTH-1:0] adr,
        input logic we,
        input logic [3:0] stb,
        input logic [31:0] dat
    );
        int cycles;
        cycles = 0;
        if (timedOut)
            return;
        @(posedge wbsClk);
        wbsAdr <= adr;
        wbsWe <= we;
        wbsByteStb <= stb;
        wbsDatWr <= dat;
        wbsCyc <= 1'b1;
        wbsStb <= 1'b1;
        // Held until acknowledge
        do
        begin
            @(posedge wbsClk);
            cycles++;
        end
        while (!wbsAck && cycles < 16);
        wbsCyc <= 1'b0;
        wbsStb <= 1'b0;
        wbsWe <= 1'b0;
        if (!wbsAck)
        begin
            $display("ERROR: no acknowledge for address %0h within 16 bus cycles", adr);
            timedOut = 1'b1;
        end
        @(posedge wbsClk);
    endtask

    // Count falling edges of vcom_o
    task automatic waitPulses(input int count);
        int seen;
        int cycles;
        logic last;
        seen = 0;
        cycles = 0;
        last = 1'b0;
        if (timedOut)
            return;
        while (seen < count)
        begin
            @(posedge clk32k);
            cycles++;
            if (last && !vcom)
                seen++;
            last = vcom;
            if (cycles > count * 700)
            begin
                $display("ERROR: only %0d of %0d vcom pulses within %0d cycles",
                         seen, count, cycles);
                timedOut = 1'b1;
                return;
            end
        end
    endtask

    // Disable reaches vcom_o within 600 cycles, then it must stay low
    task automatic settleAndWatch();
        repeat (600) @(posedge clk32k);
        mon_i.checkQuiet(600);
    endtask

    // ---------------------------------------------------------------------------
    // Test sequence
    // ---------------------------------------------------------------------------
    initial
    begin
        int reqCount;
        int pick;
        logic [`FABRIC_ADDR_WIDTH-1:0] adr;

        void'($urandom(87220));
        wbsRst = 1'b1;
        rstFb = 1'b1;
        wbsAdr = '0;
        wbsCyc = 1'b0;
        wbsStb = 1'b0;
        wbsWe = 1'b0;
        wbsByteStb = '0;
        wbsDatWr = '0;
        gpioIn = '0;
        lcdVcomEna = 1'b0;

        // Four cycles of reset in each domain
        fork
            begin
                repeat (4) @(posedge wbsClk);
                wbsRst <= 1'b0;
            end
            begin
                repeat (4) @(posedge clk32k);
                rstFb <= 1'b0;
            end
        join

        mon_i.startTest("reset values");
        for (int a = 0; a <= 4; a++)
            busAccess(7'(a), 1'b0, 4'h0, 32'h0);
        repeat (8)
            busAccess(7'($urandom_range(127, 5)), 1'b0, 4'h0, 32'h0);
        mon_i.finishTest();

        mon_i.startTest("gpio byte writes");
        repeat (40)
        begin
            adr = ($urandom_range(1, 0) == 0) ? `ADR_GPIO_OUT : `ADR_GPIO_OE;
            busAccess(adr, 1'b1, 4'($urandom()), $urandom());
            busAccess(adr, 1'b0, 4'h0, 32'h0);
        end
        mon_i.finishTest();

        // Sits on a bus clock edge here
        mon_i.startTest("gpio input view");
        repeat (20)
        begin
            gpioIn <= 22'($urandom());
            busAccess(`ADR_GPIO_IN, 1'b0, 4'h0, 32'h0);
        end
        mon_i.finishTest();

        mon_i.startTest("read-only writes");
        reqCount = 0;
        repeat (12)
        begin
            pick = $urandom_range(2, 0);
            if (pick == 0)
                adr = `ADR_DEVICE_ID;
            else if (pick == 1)
                adr = `ADR_GPIO_IN;
            else
                adr = 7'($urandom_range(127, 5));
            busAccess(adr, 1'b1, 4'hF, $urandom());
            reqCount++;
        end
        // Nothing readable may have moved
        for (int a = 0; a <= 4; a++)
        begin
            busAccess(7'(a), 1'b0, 4'h0, 32'h0);
            reqCount++;
        end
        mon_i.checkAckCount(reqCount);
        mon_i.finishTest();

        mon_i.startTest("vcom register enable");
        busAccess(`ADR_CLK_CTRL, 1'b1, 4'h1, 32'h1);
        waitPulses(3);
        busAccess(`ADR_CLK_CTRL, 1'b0, 4'h0, 32'h0);
        mon_i.finishTest();

        mon_i.startTest("vcom register disable");
        busAccess(`ADR_CLK_CTRL, 1'b1, 4'h1, 32'h0);
        settleAndWatch();
        mon_i.finishTest();

        mon_i.startTest("vcom panel enable");
        @(posedge clk32k);
        lcdVcomEna <= 1'b1;
        waitPulses(3);
        @(posedge clk32k);
        lcdVcomEna <= 1'b0;
        mon_i.finishTest();

        mon_i.startTest("vcom panel disable");
        settleAndWatch();
        mon_i.finishTest();

        $display("%0d tests run, %0d failed, %0d mismatches in total",
                 mon_i.testCount, mon_i.failedTests, mon_i.errorCount);
        if (timedOut || mon_i.errorCount != 0)
            $display("TEST RESULT: FAIL");
        else
            $display("TEST RESULT: PASS");
        $finish;
    end

endmodule
